// File: Makefile
TOP := tb_winered

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module winered_classifier_top -f filelist.f

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
+incdir+include
hdl/winered_pkg.sv
hdl/classifier_config.sv
hdl/feature_ingress.sv
hdl/bnn_paar_layer.sv
hdl/bnn_class_scorer.sv
hdl/prediction_egress.sv
hdl/winered_classifier_top.sv
testbench/tb_winered_pkg.sv
testbench/tb_winered.sv

// File: hdl/bnn_class_scorer.sv
`include "winered_settings.svh"
`include "bnn_tables.svh"

module bnn_class_scorer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    hid_valid,
    input  winered_pkg::hidden_t    hidden,
    input  winered_pkg::score_t     margin,
    output logic                    res_valid,
    output winered_pkg::class_idx_t res_class,
    output logic                    res_low_conf
);
    import winered_pkg::*;

    localparam logic [`CLASS_CNT*`HIDDEN_CNT-1:0] W1 = `BNN_W1_TABLE;

    score_t     scores [`CLASS_CNT];
    score_t     best_score;
    score_t     second_score;
    class_idx_t best_idx;
    logic       low_conf;

    // XNOR popcount per class
    always_comb begin
        hidden_t agree;
        for (int c = 0; c < `CLASS_CNT; c++) begin
            agree = ~(hidden ^ W1[c*`HIDDEN_CNT +: `HIDDEN_CNT]);
            scores[c] = '0;
            for (int j = 0; j < `HIDDEN_CNT; j++) begin
                scores[c] = scores[c] + score_t'(agree[j]);
            end
        end
    end

    // Strict compare keeps the lowest index on a tie
    always_comb begin
        best_score   = scores[0];
        best_idx     = '0;
        second_score = '0;
        for (int c = 1; c < `CLASS_CNT; c++) begin
            if (scores[c] > best_score) begin
                second_score = best_score;
                best_score   = scores[c];
                best_idx     = class_idx_t'(c);
            end else if (scores[c] > second_score) begin
                second_score = scores[c];
            end
        end
        low_conf = (best_score - second_score) < margin;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= hid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hid_valid) begin
            res_class    <= best_idx;
            res_low_conf <= low_conf;
        end
    end

endmodule

// File: hdl/bnn_paar_layer.sv
`include "winered_settings.svh"
`include "bnn_tables.svh"

module bnn_paar_layer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  winered_pkg::feat_vec_t issue_features,
    output logic                   hid_valid,
    output winered_pkg::hidden_t   hidden
);
    import winered_pkg::*;

    localparam int NODE_CNT = `FEAT_CNT + `ADD_CNT;
    localparam int NODE_BITS = $clog2(`FEAT_CNT + 1) + `FEAT_BITS + 1;
    localparam logic [`ADD_CNT*`BNN_PAAR_ENTRY-1:0] PAAR = `BNN_PAAR_TABLE;
    localparam logic [`HIDDEN_CNT*`BNN_YMAP_ENTRY-1:0] YMAP = `BNN_YMAP_TABLE;

    logic signed [NODE_BITS-1:0] node [NODE_CNT];
    hidden_t                     hidden_d;

    always_comb begin
        int op_a;
        int op_b;
        int sel;
        int base;
        // Features enter as the first nodes, always non-negative
        for (int f = 0; f < `FEAT_CNT; f++) begin
            node[f] = {{(NODE_BITS - `FEAT_BITS){1'b0}},
                       issue_features[f*`FEAT_BITS +: `FEAT_BITS]};
        end
        // Shared subexpressions, each node built from earlier ones
        for (int n = 0; n < `ADD_CNT; n++) begin
            base = n * `BNN_PAAR_ENTRY;
            op_a = int'(PAAR[base+16 +: 16]);
            op_b = int'(PAAR[base+32 +: 16]);
            if (PAAR[base]) begin
                node[`FEAT_CNT+n] = node[op_a] + node[op_b];
            end else begin
                node[`FEAT_CNT+n] = node[op_a] - node[op_b];
            end
        end
        // Sign test, polarity from the map
        for (int h = 0; h < `HIDDEN_CNT; h++) begin
            base = h * `BNN_YMAP_ENTRY;
            sel = int'(YMAP[base +: 16]);
            hidden_d[h] = YMAP[base+16] ? ~node[sel][NODE_BITS-1] : node[sel][NODE_BITS-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hid_valid <= 1'b0;
        end else begin
            hid_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            hidden <= hidden_d;
        end
    end

endmodule

// File: hdl/classifier_config.sv
module classifier_config (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_we,
    input  logic                   cfg_addr,
    input  winered_pkg::cfg_word_u cfg_wdata,
    output winered_pkg::cfg_word_u cfg_rdata,
    output logic                   enable,
    output winered_pkg::score_t    margin
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
            margin <= '0;
        end else if (cfg_we) begin
            if (cfg_addr) begin
                margin <= cfg_wdata.margin_view.value;
            end else begin
                enable <= cfg_wdata.ctrl.enable;
            end
        end
    end

    // Unused bits read back as zero
    always_comb begin
        cfg_rdata = '0;
        if (cfg_addr) begin
            cfg_rdata.margin_view.value = margin;
        end else begin
            cfg_rdata.ctrl.enable = enable;
        end
    end

endmodule

// File: hdl/feature_ingress.sv
`include "winered_settings.svh"

module feature_ingress (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   feat_valid,
    input  winered_pkg::feat_vec_t features,
    input  logic                   enable,
    input  logic                   issue_ok,
    output logic                   feat_credit,
    output logic                   issue_valid,
    output winered_pkg::feat_vec_t issue_features
);
    import winered_pkg::*;

    localparam int PTR_BITS = $clog2(`INGRESS_DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;

    feat_vec_t           fifo_mem [`INGRESS_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // Head leaves when there is work, the pipeline is on and egress has room
    assign issue_valid = (count != '0) && enable && issue_ok;
    assign issue_features = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (feat_valid) begin
            fifo_mem[wr_ptr] <= features;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            feat_credit <= 1'b0;
        end else begin
            feat_credit <= issue_valid;
            if (feat_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(`INGRESS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (issue_valid) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(`INGRESS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({feat_valid, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/prediction_egress.sv
`include "winered_settings.svh"

module prediction_egress (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue_valid,
    input  logic                    res_valid,
    input  winered_pkg::class_idx_t res_class,
    input  logic                    res_low_conf,
    input  logic                    pred_credit,
    output logic                    issue_ok,
    output logic                    pred_valid,
    output winered_pkg::class_idx_t pred_class,
    output logic                    pred_low_conf
);
    import winered_pkg::*;

    localparam int PTR_BITS = $clog2(`EGRESS_DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;

    class_idx_t                   class_mem [`EGRESS_DEPTH];
    logic                         low_conf_mem [`EGRESS_DEPTH];
    logic [PTR_BITS-1:0]          wr_ptr;
    logic [PTR_BITS-1:0]          rd_ptr;
    logic [CNT_BITS-1:0]          count;
    logic [CNT_BITS-1:0]          in_flight;
    logic [`PRED_CREDIT_BITS-1:0] credits;

    // Reserve a slot for every sample still in the pipeline
    assign issue_ok = (count + in_flight) < CNT_BITS'(`EGRESS_DEPTH);

    assign pred_valid    = (count != '0) && (credits != '0);
    assign pred_class    = class_mem[rd_ptr];
    assign pred_low_conf = low_conf_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (res_valid) begin
            class_mem[wr_ptr]    <= res_class;
            low_conf_mem[wr_ptr] <= res_low_conf;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_flight <= '0;
            credits   <= '0;
        end else begin
            if (res_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(`EGRESS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pred_valid) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(`EGRESS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({res_valid, pred_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({issue_valid, res_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
            case ({pred_credit, pred_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: hdl/winered_classifier_top.sv
module winered_classifier_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    feat_valid,
    input  winered_pkg::feat_vec_t  features,
    output logic                    feat_credit,
    output logic                    pred_valid,
    output winered_pkg::class_idx_t pred_class,
    output logic                    pred_low_conf,
    input  logic                    pred_credit,
    input  logic                    cfg_we,
    input  logic                    cfg_addr,
    input  winered_pkg::cfg_word_u  cfg_wdata,
    output winered_pkg::cfg_word_u  cfg_rdata
);
    import winered_pkg::*;

    logic       issue_valid;
    feat_vec_t  issue_features;
    logic       issue_ok;
    logic       hid_valid;
    hidden_t    hidden;
    logic       res_valid;
    class_idx_t res_class;
    logic       res_low_conf;
    logic       enable;
    score_t     margin;

    classifier_config u_config (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .enable    (enable),
        .margin    (margin)
    );

    feature_ingress u_ingress (
        .clk            (clk),
        .rst_n          (rst_n),
        .feat_valid     (feat_valid),
        .features       (features),
        .enable         (enable),
        .issue_ok       (issue_ok),
        .feat_credit    (feat_credit),
        .issue_valid    (issue_valid),
        .issue_features (issue_features)
    );

    bnn_paar_layer u_paar (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_features (issue_features),
        .hid_valid      (hid_valid),
        .hidden         (hidden)
    );

    bnn_class_scorer u_scorer (
        .clk          (clk),
        .rst_n        (rst_n),
        .hid_valid    (hid_valid),
        .hidden       (hidden),
        .margin       (margin),
        .res_valid    (res_valid),
        .res_class    (res_class),
        .res_low_conf (res_low_conf)
    );

    prediction_egress u_egress (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .res_valid     (res_valid),
        .res_class     (res_class),
        .res_low_conf  (res_low_conf),
        .pred_credit   (pred_credit),
        .issue_ok      (issue_ok),
        .pred_valid    (pred_valid),
        .pred_class    (pred_class),
        .pred_low_conf (pred_low_conf)
    );

endmodule

// File: hdl/winered_pkg.sv
`include "winered_settings.svh"

package winered_pkg;

    typedef logic [`FEAT_CNT*`FEAT_BITS-1:0] feat_vec_t;
    typedef logic [`HIDDEN_CNT-1:0] hidden_t;
    typedef logic [`SUM_BITS-1:0] score_t;
    typedef logic [$clog2(`CLASS_CNT)-1:0] class_idx_t;

    typedef struct packed {
        logic [`CFG_BITS-2:0] spare;
        logic enable;
    } cfg_ctrl_t;

    // Address 0 reads as ctrl, address 1 as margin_view
    typedef union packed {
        cfg_ctrl_t ctrl;
        struct packed {
            logic [`CFG_BITS-`SUM_BITS-1:0] pad;
            score_t value;
        } margin_view;
    } cfg_word_u;

endpackage

// File: include/bnn_tables.svh
`ifndef BNN_TABLES_SVH
`define BNN_TABLES_SVH

// Entry layouts, entry 0 at the low end of each table
`define BNN_PAAR_ENTRY 48
`define BNN_YMAP_ENTRY 32

// Per node: {op_b[15:0], op_a[15:0], 15'b0, is_add}
`define BNN_PAAR_TABLE { \
    48'h0021002a0001, \
    288'h0021002a0000_000d004e0001_000d004a0001_002600470001_001d00460001_001700450001, \
    288'h002700440001_000f00400001_0019003f0001_001e003e0001_002b003c0001_0024003b0001, \
    288'h0027003a0001_002000380001_001a00370001_002100360001_002500320001_001e00310001, \
    288'h001800300001_0017002e0001_0014002d0001_0014002c0001_002500290001_001400290001, \
    288'h001f00230001_001e00220001_0022003d0000_001900330000_001800310000_001a00300000, \
    288'h0025002f0000_0014002f0000_0012002e0000_001d002c0000_002000290000_001c00280000, \
    288'h001000280000_001c00240000_001800240000_001d00230000_001400230000_001b00220000, \
    288'h001e00210000_001a00200000_001200200000_000d001c0000_0014001a0000_001000190000, \
    288'h001000140000_0014002d0000_001a002b0000_001d00280000_001000270000_001f00230000, \
    288'h001e00220000_001a001d0000_0017001c0000_001200260001_001400170001_001000170001, \
    288'h001a001f0000_0019001c0000_000f001b0000_000d000f0000_001700180000_001800190001, \
    288'h001200130001_000f00130001_000e00160000_000c00110000_000e00160001_0012001b0001, \
    288'h001200140000_001100160001_000c00110001_001100160000_000d00100001_000c000e0001, \
    288'h000500150000_000d00100000_000500150001_000d000f0001_0005000b0000_000f00130000, \
    288'h0009000a0001_000000080001_000c000e0000_000100040001_000200070000_000300060000, \
    288'h0005000b0001_000200070001_000300060001_000100040000_0009000a0000_000000080000}

// Per hidden bit: {15'b0, positive, node[15:0]}
`define BNN_YMAP_TABLE { \
    256'h00000058_0001005d_00000055_00010051_00010050_0001006a_00010052_0001005c, \
    256'h00000064_0000005f_00010049_00010056_00000062_00010068_0000005e_00010067, \
    256'h00000061_0001005b_00000054_00000060_00000042_00010039_00010057_00000069, \
    256'h00000053_00010043_00000059_00010034_0001004b_0000006b_00010041_0001005a, \
    256'h00010065_00010066_00010035_0000004c_00010063_00010048_0001004f_0001004d}

// One row of HIDDEN_CNT weights per class, class 5 first
`define BNN_W1_TABLE { \
    40'b1010111101_0101011110_1111010101_0001011110, \
    40'b0110111011_0011111110_0100111101_0010001110, \
    40'b1000101011_1111011110_0101010100_1011000101, \
    40'b1010111000_1101100010_0010000100_1000000011, \
    40'b1100011010_0000011011_1000000111_0100111101, \
    40'b0010001011_1100000011_0111000001_0000111001}

`endif

// File: include/winered_settings.svh
`ifndef WINERED_SETTINGS_SVH
`define WINERED_SETTINGS_SVH

// Network shape
`define FEAT_CNT 11
`define FEAT_BITS 4
`define HIDDEN_CNT 40
`define CLASS_CNT 6
`define SUM_BITS 6
`define ADD_CNT 97

// Buffers and flow control
`define INGRESS_DEPTH 4
`define EGRESS_DEPTH 4
`define INGRESS_CREDITS `INGRESS_DEPTH
`define PRED_CREDIT_BITS 8

// Configuration word width
`define CFG_BITS 8

`endif

// File: testbench/tb_winered.sv
`include "winered_settings.svh"

module tb_winered;
    import winered_pkg::*;
    import tb_winered_pkg::*;

    localparam int DIRECTED_CNT = `FEAT_CNT + 2;
    localparam int RANDOM_CNT = 60;
    localparam int SLOW_CNT = 12;
    localparam int MARGIN_CNT = 15;
    localparam int SAMPLE_CNT = `INGRESS_DEPTH + DIRECTED_CNT + RANDOM_CNT + SLOW_CNT
                                + 3 * MARGIN_CNT;
    localparam int CYCLE_LIMIT = SAMPLE_CNT * 20 + 200;

    logic       clk;
    logic       rst_n;
    logic       feat_valid;
    feat_vec_t  features;
    logic       feat_credit;
    logic       pred_valid;
    class_idx_t pred_class;
    logic       pred_low_conf;
    logic       pred_credit;
    logic       cfg_we;
    logic       cfg_addr;
    cfg_word_u  cfg_wdata;
    cfg_word_u  cfg_rdata;

    // Scoreboard with one entry per sample sent
    class_idx_t exp_class [$];
    bit         exp_flag [$];
    int         up_credits;
    int         feat_credit_cnt;
    int         pred_cnt;
    int         granted;
    int         cycle_cnt = 0;
    score_t     cur_margin;

    winered_classifier_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .feat_valid    (feat_valid),
        .features      (features),
        .feat_credit   (feat_credit),
        .pred_valid    (pred_valid),
        .pred_class    (pred_class),
        .pred_low_conf (pred_low_conf),
        .pred_credit   (pred_credit),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_class(input string name, input class_idx_t got, input class_idx_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %0b, expected %0b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cfg(input string name, input cfg_word_u got, input cfg_word_u exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got 0x%02h, expected 0x%02h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Output monitor and credit bookkeeping
    always @(posedge clk) begin
        class_idx_t want_class;
        bit         want_flag;
        if (rst_n) begin
            if (pred_valid) begin
                pred_cnt++;
                if (pred_cnt > granted) begin
                    $display("A prediction left the DUT without a granted credit");
                    abort_run();
                end else if (exp_class.size() == 0) begin
                    $display("A prediction arrived with no sample outstanding");
                    abort_run();
                end else begin
                    want_class = exp_class.pop_front();
                    want_flag = exp_flag.pop_front();
                    check_class("pred_class", pred_class, want_class);
                    check_flag("pred_low_conf", pred_low_conf, want_flag);
                end
            end
            if (pred_credit) begin
                granted++;
            end
            if (feat_credit) begin
                feat_credit_cnt++;
                up_credits++;
                if (up_credits > `INGRESS_DEPTH) begin
                    $display("The DUT returned more upstream credits than samples sent");
                    abort_run();
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic send_sample(input feat_vec_t f);
        class_idx_t cls;
        bit         flag;
        while (up_credits == 0) begin
            @(negedge clk);
        end
        model_classify(f, cur_margin, cls, flag);
        exp_class.push_back(cls);
        exp_flag.push_back(flag);
        feat_valid = 1'b1;
        features = f;
        up_credits--;
        @(negedge clk);
        feat_valid = 1'b0;
    endtask

    task automatic write_config(input logic addr, input cfg_word_u word);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = word;
        if (addr) begin
            cur_margin = word.margin_view.value;
        end
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic expect_config_read(input logic addr, input cfg_word_u exp, input string name);
        cfg_addr = addr;
        @(posedge clk);
        check_cfg(name, cfg_rdata, exp);
        @(negedge clk);
    endtask

    task automatic grant_credits(input int n);
        repeat (n) begin
            pred_credit = 1'b1;
            @(negedge clk);
            pred_credit = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        while (exp_class.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic idle_after_reset();
        cfg_word_u zero_word;
        zero_word = '0;
        expect_config_read(1'b0, zero_word, "cfg_rdata control");
        expect_config_read(1'b1, zero_word, "cfg_rdata margin");
        for (int i = 0; i < `INGRESS_DEPTH; i++) begin
            send_sample(random_features());
        end
        repeat (40) @(negedge clk);
        if (pred_cnt != 0 || feat_credit_cnt != 0) begin
            $display("The DUT produced output or credits while the pipeline was disabled");
            abort_run();
        end
    endtask

    task automatic upstream_credit_return();
        cfg_word_u w;
        w = '0;
        w.ctrl.enable = 1'b1;
        write_config(1'b0, w);
        while (feat_credit_cnt < `INGRESS_DEPTH) begin
            @(negedge clk);
        end
        // Any further pulse trips the monitor
        repeat (20) @(negedge clk);
        grant_credits(`INGRESS_DEPTH);
        wait_drain();
    endtask

    task automatic config_views();
        cfg_word_u ctrl_word;
        cfg_word_u margin_word;
        ctrl_word = '0;
        write_config(1'b0, ctrl_word);
        expect_config_read(1'b0, ctrl_word, "cfg_rdata control");
        ctrl_word.ctrl.enable = 1'b1;
        write_config(1'b0, ctrl_word);
        expect_config_read(1'b0, ctrl_word, "cfg_rdata control");
        margin_word = '0;
        margin_word.margin_view.value = score_t'(21);
        write_config(1'b1, margin_word);
        expect_config_read(1'b1, margin_word, "cfg_rdata margin");
        expect_config_read(1'b0, ctrl_word, "cfg_rdata control");
        margin_word = '0;
        write_config(1'b1, margin_word);
        expect_config_read(1'b1, margin_word, "cfg_rdata margin");
    endtask

    task automatic directed_stream();
        feat_vec_t f;
        grant_credits(DIRECTED_CNT + RANDOM_CNT);
        send_sample('0);
        send_sample('1);
        // One feature at full scale and the rest zero
        for (int i = 0; i < `FEAT_CNT; i++) begin
            f = '0;
            f[i*`FEAT_BITS +: `FEAT_BITS] = '1;
            send_sample(f);
        end
        repeat (RANDOM_CNT) send_sample(random_features());
        wait_drain();
    endtask

    task automatic slow_credit_drain();
        fork
            begin
                repeat (SLOW_CNT) send_sample(random_features());
            end
            begin
                repeat (SLOW_CNT) begin
                    repeat (7) @(negedge clk);
                    pred_credit = 1'b1;
                    @(negedge clk);
                    pred_credit = 1'b0;
                end
            end
        join
        wait_drain();
    endtask

    task automatic margin_flags();
        cfg_word_u w;
        int        margin_list [3];
        margin_list[0] = 0;
        margin_list[1] = 3;
        margin_list[2] = 40;
        for (int m = 0; m < 3; m++) begin
            w = '0;
            w.margin_view.value = score_t'(margin_list[m]);
            write_config(1'b1, w);
            grant_credits(MARGIN_CNT);
            repeat (MARGIN_CNT) send_sample(random_features());
            wait_drain();
        end
    endtask

    initial begin
        void'($urandom(292));
        clk = 1'b0;
        rst_n = 1'b0;
        feat_valid = 1'b0;
        features = '0;
        pred_credit = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = 1'b0;
        cfg_wdata = '0;
        up_credits = `INGRESS_DEPTH;
        feat_credit_cnt = 0;
        pred_cnt = 0;
        granted = 0;
        cur_margin = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        upstream_credit_return();
        config_views();
        directed_stream();
        slow_credit_drain();
        margin_flags();

        // Quiet tail so a stray prediction still reaches the monitor
        repeat (10) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: testbench/tb_winered_pkg.sv
`include "winered_settings.svh"
`include "bnn_tables.svh"

package tb_winered_pkg;
    import winered_pkg::*;

    localparam logic [`ADD_CNT*`BNN_PAAR_ENTRY-1:0] PAAR_TBL = `BNN_PAAR_TABLE;
    localparam logic [`HIDDEN_CNT*`BNN_YMAP_ENTRY-1:0] YMAP_TBL = `BNN_YMAP_TABLE;
    localparam logic [`CLASS_CNT*`HIDDEN_CNT-1:0] W1_TBL = `BNN_W1_TABLE;

    // Integer network, features first, then one value per add/subtract node
    function automatic void model_classify(input feat_vec_t feat, input score_t margin,
                                           output class_idx_t cls, output bit low_conf);
        int                         val [`FEAT_CNT+`ADD_CNT];
        int                         score [`CLASS_CNT];
        bit                         hid [`HIDDEN_CNT];
        logic [`BNN_PAAR_ENTRY-1:0] ent;
        logic [`BNN_YMAP_ENTRY-1:0] yent;
        int                         best;
        int                         runner;
        for (int f = 0; f < `FEAT_CNT; f++) begin
            val[f] = int'(feat[f*`FEAT_BITS +: `FEAT_BITS]);
        end
        for (int n = 0; n < `ADD_CNT; n++) begin
            ent = PAAR_TBL[n*`BNN_PAAR_ENTRY +: `BNN_PAAR_ENTRY];
            if (ent[0]) begin
                val[`FEAT_CNT+n] = val[ent[31:16]] + val[ent[47:32]];
            end else begin
                val[`FEAT_CNT+n] = val[ent[31:16]] - val[ent[47:32]];
            end
        end
        for (int h = 0; h < `HIDDEN_CNT; h++) begin
            yent = YMAP_TBL[h*`BNN_YMAP_ENTRY +: `BNN_YMAP_ENTRY];
            hid[h] = yent[16] ? (val[yent[15:0]] >= 0) : (val[yent[15:0]] < 0);
        end
        for (int c = 0; c < `CLASS_CNT; c++) begin
            score[c] = 0;
            for (int j = 0; j < `HIDDEN_CNT; j++) begin
                if (hid[j] == W1_TBL[c*`HIDDEN_CNT + j]) begin
                    score[c]++;
                end
            end
        end
        best = 0;
        for (int c = 1; c < `CLASS_CNT; c++) begin
            if (score[c] > score[best]) begin
                best = c;
            end
        end
        // Runner-up is the best of the other classes
        runner = -1;
        for (int c = 0; c < `CLASS_CNT; c++) begin
            if (c != best && score[c] > runner) begin
                runner = score[c];
            end
        end
        cls = class_idx_t'(best);
        low_conf = (score[best] - runner) < int'(margin);
    endfunction

    function automatic feat_vec_t random_features();
        feat_vec_t f;
        for (int i = 0; i < `FEAT_CNT; i++) begin
            f[i*`FEAT_BITS +: `FEAT_BITS] = `FEAT_BITS'($urandom_range(15, 0));
        end
        return f;
    endfunction

endpackage
